// File: hdl/dcache_pkg.sv
`default_nettype none

package dcache_pkg;

	// organisation of the cache
	localparam int NUM_WAYS = 4;
	localparam int NUM_SETS = 16;
	localparam int LANE_W = 32;
	localparam int LANES_PER_ROW = 4;
	localparam int ROWS_PER_LINE = 4;

	// one refill beat fills one lane
	localparam int BEATS_PER_LINE = LANES_PER_ROW * ROWS_PER_LINE;

	// address fields of a 64-byte line
	localparam int HALF_BIT = 3;
	localparam int ROW_LSB = 4;
	localparam int ROW_SEL_W = 2;
	localparam int SET_LSB = 6;
	localparam int SET_W = 4;
	localparam int TAG_LSB = SET_LSB + SET_W;
	localparam int TAG_W = 22;

	// zero or one bit set
	typedef logic [NUM_WAYS-1:0] way_onehot_t;

	// a quarter of a line, lane 0 in the low bits
	typedef logic [LANES_PER_ROW*LANE_W-1:0] line_row_t;

	typedef logic [TAG_W-1:0] tag_t;
	typedef logic [SET_W-1:0] set_idx_t;

	// set index, then row within the line
	typedef logic [SET_W+ROW_SEL_W-1:0] row_addr_t;

endpackage

`default_nettype wire

// File: hdl/axi_rd_pkg.sv
`default_nettype none

package axi_rd_pkg;

	// burst type and beat size codes of the read address channel
	localparam logic [1:0] BURST_INCR = 2'b01;
	localparam logic [2:0] BEAT_SIZE_4B = 3'b010;

	// one read data beat
	typedef logic [31:0] beat_t;

	// beats in the burst minus one
	typedef logic [7:0] burst_len_t;

endpackage

`default_nettype wire

// File: hdl/dcache_tag_array.sv
`timescale 1ns/1ns
`default_nettype none

module dcache_tag_array
	import dcache_pkg::*;
(
	input wire clk,
	input wire rst,
	input wire set_idx_t lookup_set,
	input wire tag_t lookup_tag,
	input wire fill_en,
	input wire way_onehot_t fill_way,
	input wire inval_en,
	output way_onehot_t way_hit
);

	tag_t tags [NUM_WAYS][NUM_SETS];
	logic [NUM_SETS-1:0] vbits [NUM_WAYS];

	// compare all ways of the addressed set
	always_comb begin
		for (int w = 0; w < NUM_WAYS; w++) begin
			way_hit[w] = vbits[w][lookup_set] && (tags[w][lookup_set] == lookup_tag);
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int w = 0; w < NUM_WAYS; w++) begin
				vbits[w] <= '0;
			end
		end else begin
			for (int w = 0; w < NUM_WAYS; w++) begin
				if (fill_en && fill_way[w]) begin
					vbits[w][lookup_set] <= 1'b1;
				end else if (inval_en && way_hit[w]) begin
					// written line leaves the cache
					vbits[w][lookup_set] <= 1'b0;
				end
			end
		end
	end

	// tag only matters once its valid bit is set
	always_ff @(posedge clk) begin
		for (int w = 0; w < NUM_WAYS; w++) begin
			if (fill_en && fill_way[w]) begin
				tags[w][lookup_set] <= lookup_tag;
			end
		end
	end

	// a line is never filled into a second way while still cached
	a_hit_onehot: assert property (@(posedge clk) disable iff (rst)
		$onehot0(way_hit));

endmodule

`default_nettype wire

// File: hdl/dcache_data_ram.sv
`timescale 1ns/1ns
`default_nettype none

module dcache_data_ram
	import dcache_pkg::*;
(
	input wire clk,
	input wire en,
	input wire we,
	input wire [LANES_PER_ROW-1:0] lane_we,
	input wire row_addr_t row_addr,
	input wire line_row_t wdata,
	output line_row_t rdata
);

	line_row_t mem [2**$bits(row_addr_t)];

	// single port, read data appears the cycle after en
	always_ff @(posedge clk) begin
		if (en) begin
			if (we) begin
				for (int l = 0; l < LANES_PER_ROW; l++) begin
					if (lane_we[l]) begin
						mem[row_addr][l*LANE_W +: LANE_W] <= wdata[l*LANE_W +: LANE_W];
					end
				end
			end else begin
				rdata <= mem[row_addr];
			end
		end
	end

endmodule

`default_nettype wire

// File: hdl/dcache_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module dcache_ctrl
	import dcache_pkg::*;
(
	input wire clk,
	input wire rst,
	input wire valid,
	input wire wren,
	input wire way_onehot_t way_hit,
	input wire arready,
	input wire rvalid,
	input wire rlast,
	output logic arvalid,
	output logic refilling,
	output logic [3:0] beat_cnt,
	output way_onehot_t victim_way,
	output logic fill_en,
	output way_onehot_t hit_way_q,
	output logic ready,
	output logic mem_wr
);

	typedef enum logic {
		S_IDLE,
		S_REFILL
	} state_t;

	state_t state;
	state_t state_next;
	way_onehot_t repl_ptr;
	logic req;
	logic hit;

	// the request is still held during its ready cycle, so skip it there
	assign req = (state == S_IDLE) && valid && !ready;
	assign hit = |way_hit;

	assign refilling = (state == S_REFILL);
	assign arvalid = req && !wren && !hit;
	assign mem_wr = req && wren;
	assign fill_en = refilling && rvalid && rlast;
	assign victim_way = repl_ptr;

	always_comb begin
		state_next = state;
		case (state)
			S_IDLE: begin
				if (arvalid && arready) begin
					state_next = S_REFILL;
				end
			end
			S_REFILL: begin
				if (rvalid && rlast) begin
					state_next = S_IDLE;
				end
			end
			default: state_next = S_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= S_IDLE;
			ready <= 1'b0;
			hit_way_q <= '0;
			beat_cnt <= '0;
			repl_ptr <= way_onehot_t'(1);
		end else begin
			state <= state_next;
			// hits and writes finish one cycle after acceptance
			ready <= req && (wren || hit);
			hit_way_q <= (req && !wren) ? way_hit : '0;
			if (refilling) begin
				if (rvalid) begin
					beat_cnt <= beat_cnt + 4'd1;
				end
			end else begin
				beat_cnt <= '0;
				// pointer frozen while a refill uses it
				repl_ptr <= {repl_ptr[NUM_WAYS-2:0], repl_ptr[NUM_WAYS-1]};
			end
		end
	end

	a_no_ready_in_refill: assert property (@(posedge clk) disable iff (rst)
		refilling |-> !ready);

	a_repl_onehot: assert property (@(posedge clk) disable iff (rst)
		$onehot(repl_ptr));

endmodule

`default_nettype wire

// File: hdl/dcache.sv
`timescale 1ns/1ns
`default_nettype none

module dcache
	import dcache_pkg::*;
	import axi_rd_pkg::*;
(
	input wire clk,
	input wire rst,
	input wire valid,
	input wire [63:0] addr,
	input wire wren,
	input wire [63:0] din,
	input wire [63:0] mask,
	output logic ready,
	output logic [63:0] dout,
	output logic [31:0] araddr,
	output burst_len_t arlen,
	output logic [2:0] arsize,
	output logic [1:0] arburst,
	output logic arvalid,
	input wire arready,
	input wire beat_t rdata,
	input wire rvalid,
	input wire rlast,
	output logic rready,
	output logic mem_wr,
	output logic [31:0] mem_waddr,
	output logic [63:0] mem_wdata,
	output logic [63:0] mem_wmask
);

	localparam int HALF_W = $bits(line_row_t) / 2;

	set_idx_t set_idx;
	tag_t req_tag;
	row_addr_t row_addr;
	way_onehot_t way_hit;
	way_onehot_t victim_way;
	way_onehot_t hit_way_q;
	logic refilling;
	logic fill_en;
	logic [3:0] beat_cnt;
	logic [LANES_PER_ROW-1:0] lane_sel;
	line_row_t fill_row;
	line_row_t ram_rdata [NUM_WAYS];
	line_row_t sel_row;

	assign set_idx = addr[SET_LSB +: SET_W];
	assign req_tag = addr[TAG_LSB +: TAG_W];

	// refill walks the rows of the line, four beats per row
	assign row_addr = refilling ? {set_idx, beat_cnt[3:2]} : {set_idx, addr[ROW_LSB +: ROW_SEL_W]};
	assign lane_sel = refilling ? ({{(LANES_PER_ROW-1){1'b0}}, 1'b1} << beat_cnt[1:0]) : '0;
	assign fill_row = {LANES_PER_ROW{rdata}};

	// fixed line burst
	assign araddr = {addr[31:SET_LSB], {SET_LSB{1'b0}}};
	assign arlen = burst_len_t'(BEATS_PER_LINE - 1);
	assign arsize = BEAT_SIZE_4B;
	assign arburst = BURST_INCR;
	assign rready = 1'b1;

	// write-through, doubleword aligned
	assign mem_waddr = {addr[31:HALF_BIT], {HALF_BIT{1'b0}}};
	assign mem_wdata = din;
	assign mem_wmask = mask;

	dcache_tag_array u_tags (
		.clk(clk),
		.rst(rst),
		.lookup_set(set_idx),
		.lookup_tag(req_tag),
		.fill_en(fill_en),
		.fill_way(victim_way),
		.inval_en(mem_wr),
		.way_hit(way_hit)
	);

	for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
		logic ram_en;

		// idle reads the hitting way, refill writes the victim
		assign ram_en = refilling ? (rvalid && victim_way[w]) : (valid && way_hit[w]);

		dcache_data_ram u_ram (
			.clk(clk),
			.en(ram_en),
			.we(refilling),
			.lane_we(lane_sel),
			.row_addr(row_addr),
			.wdata(fill_row),
			.rdata(ram_rdata[w])
		);
	end

	dcache_ctrl u_ctrl (
		.clk(clk),
		.rst(rst),
		.valid(valid),
		.wren(wren),
		.way_hit(way_hit),
		.arready(arready),
		.rvalid(rvalid),
		.rlast(rlast),
		.arvalid(arvalid),
		.refilling(refilling),
		.beat_cnt(beat_cnt),
		.victim_way(victim_way),
		.fill_en(fill_en),
		.hit_way_q(hit_way_q),
		.ready(ready),
		.mem_wr(mem_wr)
	);

	// registered hit way picks its RAM row
	always_comb begin
		sel_row = '0;
		for (int w = 0; w < NUM_WAYS; w++) begin
			if (hit_way_q[w]) begin
				sel_row = sel_row | ram_rdata[w];
			end
		end
	end

	assign dout = addr[HALF_BIT] ? sel_row[2*HALF_W-1:HALF_W] : sel_row[HALF_W-1:0];

endmodule

`default_nettype wire

// File: hdl/axi_burst_mem.sv
`timescale 1ns/1ns
`default_nettype none

module axi_burst_mem
	import axi_rd_pkg::*;
#(
	parameter int unsigned MEM_WORDS = 4096,
	parameter int unsigned MEM_LATENCY = 3,
	parameter logic [31:0] MEM_BASE = 32'h8000_0000
) (
	input wire clk,
	input wire rst,
	input wire [31:0] araddr,
	input wire burst_len_t arlen,
	input wire [2:0] arsize,
	input wire [1:0] arburst,
	input wire arvalid,
	output logic arready,
	output beat_t rdata,
	output logic rvalid,
	output logic rlast,
	input wire rready,
	input wire mem_wr,
	input wire [31:0] mem_waddr,
	input wire [63:0] mem_wdata,
	input wire [63:0] mem_wmask
);

	// MEM_WORDS a power of two, so the index wraps on its own
	localparam int IDX_W = $clog2(MEM_WORDS);
	localparam int WAIT_W = $clog2(MEM_LATENCY + 1);

	beat_t mem [MEM_WORDS];
	logic busy;
	logic [WAIT_W-1:0] wait_cnt;
	burst_len_t len_q;
	burst_len_t beat_q;
	logic [IDX_W-1:0] rd_idx;
	logic [IDX_W-1:0] wr_idx;

	function automatic logic [IDX_W-1:0] word_index(input logic [31:0] byte_addr);
		logic [31:0] off;
		off = byte_addr - MEM_BASE;
		return off[IDX_W+1:2];
	endfunction

	initial begin
		for (int w = 0; w < MEM_WORDS; w++) begin
			mem[w] = beat_t'(w) ^ 32'h5A5A_0000;
		end
	end

	assign arready = !busy;
	assign rvalid = busy && (wait_cnt == '0);
	assign rlast = rvalid && (beat_q == len_q);
	assign rdata = mem[rd_idx];

	always_ff @(posedge clk) begin
		if (rst) begin
			busy <= 1'b0;
			wait_cnt <= '0;
			beat_q <= '0;
		end else if (!busy) begin
			if (arvalid) begin
				busy <= 1'b1;
				wait_cnt <= WAIT_W'(MEM_LATENCY - 1);
				beat_q <= '0;
			end
		end else if (wait_cnt != '0) begin
			wait_cnt <= wait_cnt - 1'b1;
		end else if (rready) begin
			beat_q <= beat_q + 1'b1;
			if (rlast) begin
				busy <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (arvalid && arready) begin
			len_q <= arlen;
			rd_idx <= word_index(araddr);
		end else if (rvalid && rready) begin
			rd_idx <= rd_idx + 1'b1;
		end
	end

	// masked doubleword write, low word at the even index
	assign wr_idx = word_index(mem_waddr);

	always @(posedge clk) begin
		if (mem_wr) begin
			mem[{wr_idx[IDX_W-1:1], 1'b0}] <= (mem[{wr_idx[IDX_W-1:1], 1'b0}] & ~mem_wmask[31:0])
				| (mem_wdata[31:0] & mem_wmask[31:0]);
			mem[{wr_idx[IDX_W-1:1], 1'b1}] <= (mem[{wr_idx[IDX_W-1:1], 1'b1}] & ~mem_wmask[63:32])
				| (mem_wdata[63:32] & mem_wmask[63:32]);
		end
	end

	// first beat exactly MEM_LATENCY cycles after an accepted address
	a_rvalid_in_burst: assert property (@(posedge clk) disable iff (rst)
		$rose(rvalid) |-> $past(arvalid && arready, MEM_LATENCY));

	a_burst_format: assert property (@(posedge clk) disable iff (rst)
		(arvalid && arready) |-> (arburst == BURST_INCR) && (arsize == BEAT_SIZE_4B));

endmodule

`default_nettype wire

// File: hdl/dcache_subsys.sv
`timescale 1ns/1ns
`default_nettype none

module dcache_subsys
	import axi_rd_pkg::*;
#(
	parameter int unsigned MEM_WORDS = 4096,
	parameter int unsigned MEM_LATENCY = 3,
	parameter logic [31:0] MEM_BASE = 32'h8000_0000
) (
	input wire clk,
	input wire rst,
	input wire valid,
	input wire [63:0] addr,
	input wire wren,
	input wire [63:0] din,
	input wire [63:0] mask,
	output logic ready,
	output logic [63:0] dout
);

	logic [31:0] araddr;
	burst_len_t arlen;
	logic [2:0] arsize;
	logic [1:0] arburst;
	logic arvalid;
	logic arready;
	beat_t rdata;
	logic rvalid;
	logic rlast;
	logic rready;
	logic mem_wr;
	logic [31:0] mem_waddr;
	logic [63:0] mem_wdata;
	logic [63:0] mem_wmask;

	dcache u_dcache (
		.clk(clk),
		.rst(rst),
		.valid(valid),
		.addr(addr),
		.wren(wren),
		.din(din),
		.mask(mask),
		.ready(ready),
		.dout(dout),
		.araddr(araddr),
		.arlen(arlen),
		.arsize(arsize),
		.arburst(arburst),
		.arvalid(arvalid),
		.arready(arready),
		.rdata(rdata),
		.rvalid(rvalid),
		.rlast(rlast),
		.rready(rready),
		.mem_wr(mem_wr),
		.mem_waddr(mem_waddr),
		.mem_wdata(mem_wdata),
		.mem_wmask(mem_wmask)
	);

	axi_burst_mem #(
		.MEM_WORDS(MEM_WORDS),
		.MEM_LATENCY(MEM_LATENCY),
		.MEM_BASE(MEM_BASE)
	) u_mem (
		.clk(clk),
		.rst(rst),
		.araddr(araddr),
		.arlen(arlen),
		.arsize(arsize),
		.arburst(arburst),
		.arvalid(arvalid),
		.arready(arready),
		.rdata(rdata),
		.rvalid(rvalid),
		.rlast(rlast),
		.rready(rready),
		.mem_wr(mem_wr),
		.mem_waddr(mem_waddr),
		.mem_wdata(mem_wdata),
		.mem_wmask(mem_wmask)
	);

endmodule

`default_nettype wire

// File: tb/dcache_tb.sv
`timescale 1ns/1ns
`default_nettype none

module dcache_tb;

	localparam int NUM_DIRECTED = 18;
	localparam int NUM_RANDOM = 60;
	localparam int NUM_ENTRIES = NUM_DIRECTED + NUM_RANDOM;
	localparam int TIMEOUT_CYCLES = 40 * NUM_ENTRIES + 100;
	localparam int SHADOW_WORDS = 4096;
	localparam logic [31:0] SEED = 32'h8db34873;

	// expected ready timing of an entry
	localparam logic [1:0] T_ANY = 2'd0;
	localparam logic [1:0] T_ONE = 2'd1;
	localparam logic [1:0] T_MISS = 2'd2;

	typedef struct packed {
		logic wr;
		logic [63:0] addr;
		logic [63:0] data;
		logic [63:0] mask;
		logic [1:0] timing;
	} entry_t;

	logic clk;
	logic rst;
	logic valid;
	logic [63:0] addr;
	logic wren;
	logic [63:0] din;
	logic [63:0] mask;
	logic ready;
	logic [63:0] dout;

	entry_t stim [NUM_ENTRIES];
	logic [31:0] shadow [SHADOW_WORDS];
	logic [31:0] mem_base;
	int checks = 0;
	int data_errors = 0;
	int flag_errors = 0;
	int cycles = 0;

	dcache_subsys u_dut (
		.clk(clk),
		.rst(rst),
		.valid(valid),
		.addr(addr),
		.wren(wren),
		.din(din),
		.mask(mask),
		.ready(ready),
		.dout(dout)
	);

	always #5 clk = ~clk;

	task automatic check_data(input string name, input logic [63:0] exp, input logic [63:0] act);
		checks++;
		if (act !== exp) begin
			data_errors++;
			$display("FAILED at %0t ns: %s expected %h, got %h", $time, name, exp, act);
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		checks++;
		if (act !== exp) begin
			flag_errors++;
			$display("FAILED at %0t ns: %s expected %b, got %b", $time, name, exp, act);
		end
	endtask

	// doubleword number inside the memory window
	function automatic int unsigned dword_index(input logic [63:0] a);
		logic [31:0] off;
		off = a[31:0] - mem_base;
		return (off >> 3) % (SHADOW_WORDS / 2);
	endfunction

	function automatic logic [63:0] shadow_read(input logic [63:0] a);
		int unsigned d;
		d = dword_index(a);
		return {shadow[2*d+1], shadow[2*d]};
	endfunction

	task automatic shadow_write(input logic [63:0] a, input logic [63:0] data,
			input logic [63:0] m);
		int unsigned d;
		logic [63:0] word_pair;
		d = dword_index(a);
		word_pair = {shadow[2*d+1], shadow[2*d]};
		word_pair = (word_pair & ~m) | (data & m);
		shadow[2*d] = word_pair[31:0];
		shadow[2*d+1] = word_pair[63:32];
	endtask

	task automatic set_entry(input int i, input logic wr, input logic [31:0] offset,
			input logic [63:0] data, input logic [63:0] m, input logic [1:0] timing);
		stim[i].wr = wr;
		stim[i].addr = {32'h0, mem_base + offset};
		stim[i].data = data;
		stim[i].mask = m;
		stim[i].timing = timing;
	endtask

	task automatic build_table();
		logic wr;
		logic [31:0] offset;
		// first line, both halves, then hits on it
		set_entry(0, 1'b0, 32'h000, '0, '0, T_MISS);
		set_entry(1, 1'b0, 32'h008, '0, '0, T_ONE);
		set_entry(2, 1'b0, 32'h000, '0, '0, T_ONE);
		// partial write kills the cached copy
		set_entry(3, 1'b1, 32'h008, 64'h1122_3344_5566_7788, 64'h0000_FFFF_FF00_00FF, T_ONE);
		set_entry(4, 1'b0, 32'h008, '0, '0, T_MISS);
		set_entry(5, 1'b0, 32'h038, '0, '0, T_ONE);
		// five tags in set 1, one more than the ways
		for (int n = 0; n < 5; n++) begin
			set_entry(6 + n, 1'b0, 32'h040 + n * 32'h400, '0, '0, T_MISS);
			set_entry(11 + n, 1'b0, 32'h040 + n * 32'h400, '0, '0, T_ANY);
		end
		set_entry(16, 1'b1, 32'h1040, 64'hDEAD_BEEF_0BAD_F00D, '1, T_ONE);
		set_entry(17, 1'b0, 32'h1040, '0, '0, T_MISS);
		// random mix over the lower 8 KiB
		for (int i = NUM_DIRECTED; i < NUM_ENTRIES; i++) begin
			wr = ($urandom % 3) == 0;
			offset = $urandom & 32'h0000_1FF8;
			set_entry(i, wr, offset, {$urandom, $urandom}, {$urandom, $urandom},
				wr ? T_ONE : T_ANY);
		end
	endtask

	// ready must stay a strobe of an active request
	always @(posedge clk) begin
		if (!rst && !valid) begin
			check_flag("ready with valid low", 1'b0, ready);
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("run timed out after %0d cycles, a request never finished", cycles);
			$display("Finished with errors");
			$finish;
		end
	end

	initial begin
		int unsigned seed_val;
		int lat;
		logic done;
		clk = 1'b0;
		rst = 1'b1;
		valid = 1'b0;
		addr = '0;
		wren = 1'b0;
		din = '0;
		mask = '0;
		seed_val = $urandom(SEED);
		mem_base = u_dut.MEM_BASE;
		for (int w = 0; w < SHADOW_WORDS; w++) begin
			shadow[w] = 32'(w) ^ 32'h5A5A_0000;
		end
		build_table();

		repeat (3) @(posedge clk);
		rst <= 1'b0;
		@(posedge clk);
		// quiet outputs out of reset
		check_flag("ready", 1'b0, ready);
		check_flag("arvalid", 1'b0, u_dut.arvalid);
		check_flag("mem_wr", 1'b0, u_dut.mem_wr);
		check_flag("rvalid", 1'b0, u_dut.rvalid);

		for (int i = 0; i < NUM_ENTRIES; i++) begin
			valid <= 1'b1;
			addr <= stim[i].addr;
			wren <= stim[i].wr;
			din <= stim[i].data;
			mask <= stim[i].mask;
			lat = -1;
			done = 1'b0;
			while (!done) begin
				@(posedge clk);
				lat++;
				// never in the cycle valid is first seen
				if (lat == 0) begin
					check_flag("ready", 1'b0, ready);
				end
				done = ready;
			end
			if (stim[i].wr) begin
				shadow_write(stim[i].addr, stim[i].data, stim[i].mask);
			end else begin
				check_data("dout", shadow_read(stim[i].addr), dout);
			end
			if (stim[i].timing == T_ONE) begin
				check_flag("ready one cycle after valid", 1'b1, lat == 1);
			end else if (stim[i].timing == T_MISS) begin
				check_flag("ready delayed by refill", 1'b1, lat > 1);
			end
			// idle gap now and then
			if (i % 4 == 3) begin
				valid <= 1'b0;
				@(posedge clk);
			end
		end
		valid <= 1'b0;
		@(posedge clk);
		@(negedge clk);

		$display("%0d checks, %0d data errors, %0d flag errors", checks, data_errors,
			flag_errors);
		if (data_errors == 0 && flag_errors == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog.f
hdl/dcache_pkg.sv
hdl/axi_rd_pkg.sv
hdl/dcache_tag_array.sv
hdl/dcache_data_ram.sv
hdl/dcache_ctrl.sv
hdl/dcache.sv
hdl/axi_burst_mem.sv
hdl/dcache_subsys.sv
tb/dcache_tb.sv

// File: Bender.yml
package:
  name: dcache_subsys

sources:
  - hdl/dcache_pkg.sv
  - hdl/axi_rd_pkg.sv
  - hdl/dcache_tag_array.sv
  - hdl/dcache_data_ram.sv
  - hdl/dcache_ctrl.sv
  - hdl/dcache.sv
  - hdl/axi_burst_mem.sv
  - hdl/dcache_subsys.sv
  - target: simulation
    files:
      - tb/dcache_tb.sv
